// File: common/drive_pkg.sv
package drive_pkg;

  // ********************************************************************
  // drive quantities
  // ********************************************************************

  // duty of one transducer in PWM counts.
  typedef logic [7:0] intensity_t;

  // phase offset of one transducer in counts.
  typedef logic [7:0] phase_t;

  // position within the 256-cycle modulation period.
  typedef logic [7:0] sys_time_t;

  // index of a pattern in the STM sequence.
  typedef logic [15:0] stm_idx_t;

  typedef struct packed {
    intensity_t intensity;
    phase_t     phase;
  } drive_t;

  // one entry of a per-period burst, tagged with the pattern it came from.
  // the normal source always tags its beats with zero.
  typedef struct packed {
    logic     valid;
    drive_t   drive;
    stm_idx_t stm_idx;
  } drive_beat_t;

  // ********************************************************************
  // mode control
  // ********************************************************************

  typedef struct packed {
    logic     op_mode;
    logic     use_start_idx;
    logic     use_finish_idx;
    stm_idx_t start_idx;
    stm_idx_t finish_idx;
    stm_idx_t stm_cycle;
  } stm_ctrl_t;

  typedef enum logic [1:0] {
    NORMAL,
    WAIT_START_STM,
    STM,
    WAIT_FINISH_STM
  } mux_state_t;

endpackage

// File: normal_source/normal_source.sv
`timescale 1ns/1ns

module normal_source import drive_pkg::*; #(
  parameter int NUM_TRANS = 8,
  localparam int ADDR_W = (NUM_TRANS > 1) ? $clog2(NUM_TRANS) : 1
) (
  input  logic              CLK,
  input  logic              arst_n,
  input  sys_time_t         sys_time,
  input  logic              wr_valid,
  output logic              wr_ready,
  input  logic [ADDR_W-1:0] wr_addr,
  input  drive_t            wr_drive,
  output drive_beat_t       beat
);

  drive_t drive_table [NUM_TRANS];

  logic   rd_en;
  logic   valid_q;
  drive_t drive_q;

  // the first NUM_TRANS cycles of every period belong to the burst readout.
  assign rd_en = (int'(sys_time) < NUM_TRANS);

  // the host may only write while the table is not being read.
  assign wr_ready = ~rd_en;

  // ********************************************************************
  // drive table
  // ********************************************************************

  // one drive entry per transducer, written by the host between bursts.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_TRANS; i++) begin
        drive_table[i] <= '0;
      end
    end else if (wr_valid && wr_ready) begin
      drive_table[wr_addr] <= wr_drive;
    end
  end

  // ********************************************************************
  // burst readout
  // ********************************************************************

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rd_en;
    end
  end

  // sys_time doubles as the transducer address during the readout window.
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      drive_q <= drive_table[sys_time[ADDR_W-1:0]];
    end
  end

  assign beat = drive_beat_t'{valid: valid_q, drive: drive_q, stm_idx: '0};

endmodule

// File: stm_source/stm_source.sv
`timescale 1ns/1ns

module stm_source import drive_pkg::*; #(
  parameter int NUM_TRANS = 8,
  parameter int NUM_PATTERNS = 16,
  localparam int ADDR_W = (NUM_TRANS > 1) ? $clog2(NUM_TRANS) : 1,
  localparam int PAT_W = (NUM_PATTERNS > 1) ? $clog2(NUM_PATTERNS) : 1
) (
  input  logic              CLK,
  input  logic              arst_n,
  input  sys_time_t         sys_time,
  input  stm_idx_t          stm_cycle,
  input  logic              wr_valid,
  output logic              wr_ready,
  input  logic [PAT_W-1:0]  wr_pattern,
  input  logic [ADDR_W-1:0] wr_addr,
  input  drive_t            wr_drive,
  output drive_beat_t       beat
);

  drive_t pattern_mem [NUM_PATTERNS][NUM_TRANS];

  stm_idx_t pattern_idx;
  logic     idx_wrap;
  logic     rd_en;
  logic     period_end;

  logic     valid_q;
  drive_t   drive_q;
  stm_idx_t idx_q;

  assign rd_en      = (int'(sys_time) < NUM_TRANS);
  assign wr_ready   = ~rd_en;
  assign period_end = (sys_time == '1);

  // a cycle of zero or one patterns keeps the index parked at zero.
  assign idx_wrap = ({1'b0, pattern_idx} + 17'd1) >= {1'b0, stm_cycle};

  // ********************************************************************
  // pattern index
  // ********************************************************************

  // the index moves on in the last cycle of the period, so the first burst
  // after reset reads pattern zero and each later burst reads the next one.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pattern_idx <= '0;
    end else if (period_end) begin
      if (idx_wrap) begin
        pattern_idx <= '0;
      end else begin
        pattern_idx <= pattern_idx + 16'd1;
      end
    end
  end

  // ********************************************************************
  // pattern memory
  // ********************************************************************

  always_ff @(posedge CLK) begin
    if (wr_valid && wr_ready) begin
      pattern_mem[wr_pattern][wr_addr] <= wr_drive;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rd_en;
    end
  end

  // patterns beyond the memory depth alias onto the low index bits.
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      drive_q <= pattern_mem[pattern_idx[PAT_W-1:0]][sys_time[ADDR_W-1:0]];
      idx_q   <= pattern_idx;
    end
  end

  // every beat of a burst carries the same pattern index.
  assign beat = drive_beat_t'{valid: valid_q, drive: drive_q, stm_idx: idx_q};

endmodule

// File: verilog/drive_mux.sv
`timescale 1ns/1ns

module drive_mux import drive_pkg::*; (
  input  logic        CLK,
  input  logic        arst_n,
  input  stm_ctrl_t   ctrl,
  input  drive_beat_t normal_beat,
  input  drive_beat_t stm_beat,
  output drive_beat_t beat
);

  mux_state_t state;
  logic       output_stm;
  logic       stm_at_start;
  logic       stm_at_finish;

  logic     normal_valid_q;
  drive_t   normal_drive_q;
  stm_idx_t normal_idx_q;
  logic     stm_valid_q;
  drive_t   stm_drive_q;
  stm_idx_t stm_idx_q;

  // the index match looks at the beat being registered, so the state flips
  // on the same edge that captures the first beat of the matching burst.
  assign stm_at_start  = stm_beat.valid && (stm_beat.stm_idx == ctrl.start_idx);
  assign stm_at_finish = stm_beat.valid && (stm_beat.stm_idx == ctrl.finish_idx);

  // ********************************************************************
  // stream registers
  // ********************************************************************

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      normal_valid_q <= 1'b0;
      stm_valid_q    <= 1'b0;
    end else begin
      normal_valid_q <= normal_beat.valid;
      stm_valid_q    <= stm_beat.valid;
    end
  end

  always_ff @(posedge CLK) begin
    normal_drive_q <= normal_beat.drive;
    normal_idx_q   <= normal_beat.stm_idx;
    stm_drive_q    <= stm_beat.drive;
    stm_idx_q      <= stm_beat.stm_idx;
  end

  // ********************************************************************
  // mode FSM
  // ********************************************************************

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= NORMAL;
    end else begin
      case (state)
        NORMAL: begin
          if (ctrl.op_mode) begin
            state <= ctrl.use_start_idx ? WAIT_START_STM : STM;
          end
        end
        WAIT_START_STM: begin
          if (!ctrl.op_mode) begin
            state <= NORMAL;
          end else if (stm_at_start) begin
            state <= STM;
          end
        end
        STM: begin
          if (!ctrl.op_mode) begin
            state <= ctrl.use_finish_idx ? WAIT_FINISH_STM : NORMAL;
          end
        end
        WAIT_FINISH_STM: begin
          if (ctrl.op_mode) begin
            state <= STM;
          end else if (stm_at_finish) begin
            state <= NORMAL;
          end
        end
        default: begin
          state <= NORMAL;
        end
      endcase
    end
  end

  // while waiting to finish, the STM stream keeps playing.
  assign output_stm = (state == STM) || (state == WAIT_FINISH_STM);

  assign beat = output_stm ?
      drive_beat_t'{valid: stm_valid_q, drive: stm_drive_q, stm_idx: stm_idx_q} :
      drive_beat_t'{valid: normal_valid_q, drive: normal_drive_q, stm_idx: normal_idx_q};

endmodule

// File: verilog/drive_distributor.sv
`timescale 1ns/1ns

module drive_distributor import drive_pkg::*; #(
  parameter int NUM_TRANS = 8,
  localparam int ADDR_W = (NUM_TRANS > 1) ? $clog2(NUM_TRANS) : 1
) (
  input  logic        CLK,
  input  logic        arst_n,
  input  drive_beat_t beat,
  output sys_time_t   sys_time,
  output drive_t      channel_drive [NUM_TRANS],
  output logic        load
);

  localparam logic [ADDR_W-1:0] LAST_CH = ADDR_W'(NUM_TRANS - 1);

  sys_time_t         time_q;
  logic [ADDR_W-1:0] beat_cnt;
  drive_t            drive_q [NUM_TRANS];

  // ********************************************************************
  // period counter
  // ********************************************************************

  // the counter runs freely and wraps at 256.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      time_q <= '0;
    end else begin
      time_q <= time_q + 8'd1;
    end
  end

  assign sys_time = time_q;

  // the channels take the collected burst on the last cycle of the period.
  assign load = (time_q == '1);

  // ********************************************************************
  // burst collection
  // ********************************************************************

  // the burst reaches this block a couple of cycles into the period, so
  // clearing the count at time zero realigns it before any beat arrives.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      beat_cnt <= '0;
    end else if (beat.valid) begin
      if (beat_cnt == LAST_CH) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end else if (time_q == '0) begin
      beat_cnt <= '0;
    end
  end

  always_ff @(posedge CLK) begin
    if (beat.valid) begin
      drive_q[beat_cnt] <= beat.drive;
    end
  end

  assign channel_drive = drive_q;

endmodule

// File: verilog/pwm_channel.sv
`timescale 1ns/1ns

module pwm_channel import drive_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  input  sys_time_t sys_time,
  input  logic      load,
  input  drive_t    drive,
  output logic      pwm
);

  drive_t    active_q;
  sys_time_t shifted_time;

  // the pending drive is held by the distributor, the active one here.
  // a fresh value takes effect at the start of the next period.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      active_q <= '0;
    end else if (load) begin
      active_q <= drive;
    end
  end

  // the phase shifts the pulse around the period, wrapping at 256.
  assign shifted_time = sys_time + active_q.phase;

  // zero intensity never fires, so the output is low out of reset.
  assign pwm = (shifted_time < active_q.intensity);

endmodule

// File: verilog/transducer_array.sv
`timescale 1ns/1ns

module transducer_array import drive_pkg::*; #(
  parameter int NUM_TRANS = 8,
  parameter int NUM_PATTERNS = 16,
  localparam int ADDR_W = (NUM_TRANS > 1) ? $clog2(NUM_TRANS) : 1,
  localparam int PAT_W = (NUM_PATTERNS > 1) ? $clog2(NUM_PATTERNS) : 1
) (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  stm_ctrl_t            ctrl,
  input  logic                 normal_wr_valid,
  output logic                 normal_wr_ready,
  input  logic [ADDR_W-1:0]    normal_wr_addr,
  input  drive_t               normal_wr_drive,
  input  logic                 stm_wr_valid,
  output logic                 stm_wr_ready,
  input  logic [PAT_W-1:0]     stm_wr_pattern,
  input  logic [ADDR_W-1:0]    stm_wr_addr,
  input  drive_t               stm_wr_drive,
  output sys_time_t            sys_time,
  output logic [NUM_TRANS-1:0] pwm
);

  drive_beat_t normal_beat;
  drive_beat_t stm_beat;
  drive_beat_t mux_beat;
  drive_t      channel_drive [NUM_TRANS];
  logic        load;

  // ********************************************************************
  // drive sources
  // ********************************************************************

  normal_source #(
    .NUM_TRANS (NUM_TRANS)
  ) normal_source_inst (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .sys_time (sys_time),
    .wr_valid (normal_wr_valid),
    .wr_ready (normal_wr_ready),
    .wr_addr  (normal_wr_addr),
    .wr_drive (normal_wr_drive),
    .beat     (normal_beat)
  );

  stm_source #(
    .NUM_TRANS    (NUM_TRANS),
    .NUM_PATTERNS (NUM_PATTERNS)
  ) stm_source_inst (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .sys_time   (sys_time),
    .stm_cycle  (ctrl.stm_cycle),
    .wr_valid   (stm_wr_valid),
    .wr_ready   (stm_wr_ready),
    .wr_pattern (stm_wr_pattern),
    .wr_addr    (stm_wr_addr),
    .wr_drive   (stm_wr_drive),
    .beat       (stm_beat)
  );

  // ********************************************************************
  // selection, distribution and PWM
  // ********************************************************************

  drive_mux drive_mux_inst (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .ctrl        (ctrl),
    .normal_beat (normal_beat),
    .stm_beat    (stm_beat),
    .beat        (mux_beat)
  );

  drive_distributor #(
    .NUM_TRANS (NUM_TRANS)
  ) drive_distributor_inst (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .beat          (mux_beat),
    .sys_time      (sys_time),
    .channel_drive (channel_drive),
    .load          (load)
  );

  for (genvar i = 0; i < NUM_TRANS; i++) begin : g_channel
    pwm_channel pwm_channel_inst (
      .CLK      (CLK),
      .arst_n   (arst_n),
      .sys_time (sys_time),
      .load     (load),
      .drive    (channel_drive[i]),
      .pwm      (pwm[i])
    );
  end

endmodule

// File: verification/drive_model.svh
`ifndef DRIVE_MODEL_SVH
`define DRIVE_MODEL_SVH

// **********************************************************************
// reference model of the drive path
// **********************************************************************

// host view of both tables, updated as each write is accepted.
drive_t     model_normal  [NUM_TRANS];
drive_t     model_stm     [NUM_PATTERNS][NUM_TRANS];

// burst collected in the current period and drive playing right now.
drive_t     model_pending [NUM_TRANS];
drive_t     model_active  [NUM_TRANS];

stm_idx_t   model_idx;
mux_state_t model_state;
int         model_period;

function automatic void reset_model();
  for (int i = 0; i < NUM_TRANS; i++) begin
    model_normal[i]  = '0;
    model_pending[i] = '0;
    model_active[i]  = '0;
  end
  model_idx    = '0;
  model_state  = NORMAL;
  model_period = 0;
endfunction

// mode transitions that depend only on the op_mode level.
function automatic void settle_mode(input stm_ctrl_t c);
  case (model_state)
    NORMAL: begin
      if (c.op_mode) begin
        model_state = c.use_start_idx ? WAIT_START_STM : STM;
      end
    end
    WAIT_START_STM: begin
      if (!c.op_mode) begin
        model_state = NORMAL;
      end
    end
    STM: begin
      if (!c.op_mode) begin
        model_state = c.use_finish_idx ? WAIT_FINISH_STM : NORMAL;
      end
    end
    default: begin
      if (c.op_mode) begin
        model_state = STM;
      end
    end
  endcase
endfunction

// called in the first cycle of each period, before the burst is read.
function automatic void start_period(input stm_ctrl_t c);
  int pat;
  bit use_stm;
  // the load at the end of the last period made the collected burst live.
  for (int i = 0; i < NUM_TRANS; i++) begin
    model_active[i] = model_pending[i];
  end
  // the burst of period p plays pattern p mod stm_cycle.
  if (c.stm_cycle != '0) begin
    model_idx = stm_idx_t'(model_period % int'(c.stm_cycle));
  end else begin
    model_idx = '0;
  end
  // a pending switch is decided by the index of the burst itself.
  if (model_state == WAIT_START_STM && c.op_mode && model_idx == c.start_idx) begin
    model_state = STM;
  end else if (model_state == WAIT_FINISH_STM && !c.op_mode && model_idx == c.finish_idx) begin
    model_state = NORMAL;
  end
  use_stm = (model_state == STM) || (model_state == WAIT_FINISH_STM);
  pat     = int'(model_idx) % NUM_PATTERNS;
  for (int i = 0; i < NUM_TRANS; i++) begin
    model_pending[i] = use_stm ? model_stm[pat][i] : model_normal[i];
  end
  model_period++;
endfunction

function automatic logic [NUM_TRANS-1:0] predict_pwm(input sys_time_t t);
  logic [NUM_TRANS-1:0] result;
  sys_time_t            shifted;
  for (int i = 0; i < NUM_TRANS; i++) begin
    shifted   = t + model_active[i].phase;
    result[i] = (shifted < model_active[i].intensity);
  end
  return result;
endfunction

`endif

// File: verification/transducer_array_tb.sv
`timescale 1ns/1ns

module transducer_array_tb import drive_pkg::*; ();

  localparam int NUM_TRANS     = 8;
  localparam int NUM_PATTERNS  = 16;
  localparam int ADDR_W        = $clog2(NUM_TRANS);
  localparam int PAT_W         = $clog2(NUM_PATTERNS);
  localparam int FILL_WRITES   = NUM_PATTERNS * NUM_TRANS;
  localparam int NUM_PERIODS   = 24;
  localparam int PERIOD_CYCLES = 256;
  localparam int RESET_CYCLES  = 16;
  localparam int CLK_PERIOD_NS = 4;
  localparam int MODE_TIME     = 128;
  localparam int TIMEOUT_NS    =
      2 * CLK_PERIOD_NS * (RESET_CYCLES + NUM_PERIODS * PERIOD_CYCLES);
  localparam logic [31:0] SEED      = 32'he0ba;
  localparam stm_idx_t    STM_CYCLE = 16'd5;

  logic                 CLK = 1'b0;
  logic                 arst_n;
  stm_ctrl_t            ctrl;
  logic                 normal_wr_valid;
  logic                 normal_wr_ready;
  logic [ADDR_W-1:0]    normal_wr_addr;
  drive_t               normal_wr_drive;
  logic                 stm_wr_valid;
  logic                 stm_wr_ready;
  logic [PAT_W-1:0]     stm_wr_pattern;
  logic [ADDR_W-1:0]    stm_wr_addr;
  drive_t               stm_wr_drive;
  sys_time_t            sys_time;
  logic [NUM_TRANS-1:0] pwm;

  logic normal_accept;
  logic stm_accept;
  int   stm_fill_cnt;

  `include "drive_model.svh"

  transducer_array transducer_array_inst (
    .CLK             (CLK),
    .arst_n          (arst_n),
    .ctrl            (ctrl),
    .normal_wr_valid (normal_wr_valid),
    .normal_wr_ready (normal_wr_ready),
    .normal_wr_addr  (normal_wr_addr),
    .normal_wr_drive (normal_wr_drive),
    .stm_wr_valid    (stm_wr_valid),
    .stm_wr_ready    (stm_wr_ready),
    .stm_wr_pattern  (stm_wr_pattern),
    .stm_wr_addr     (stm_wr_addr),
    .stm_wr_drive    (stm_wr_drive),
    .sys_time        (sys_time),
    .pwm             (pwm)
  );

  always #(CLK_PERIOD_NS / 2) CLK = ~CLK;

  // **********************************************************************
  // compare tasks
  // **********************************************************************

  task automatic check_time(input string name, input sys_time_t got, input sys_time_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_pwm(input string name, input logic [NUM_TRANS-1:0] got,
                           input logic [NUM_TRANS-1:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h at sys_time 0x%h", name, got, exp, sys_time);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // **********************************************************************
  // host writes
  // **********************************************************************

  // a request stays on the port until it is taken; idle cycles are random.
  task automatic drive_normal_write();
    if (!normal_wr_valid || normal_accept) begin
      normal_wr_valid = ($urandom_range(3) != 0);
      normal_wr_addr  = ADDR_W'($urandom_range(NUM_TRANS - 1));
      normal_wr_drive = 16'($urandom);
    end
    // ready is stable until the next edge, so the write lands there.
    normal_accept = normal_wr_valid && normal_wr_ready;
    if (normal_accept) begin
      model_normal[normal_wr_addr] = normal_wr_drive;
    end
  endtask

  // the whole pattern memory is filled in order first, then written at random.
  task automatic drive_stm_write();
    if (!stm_wr_valid || stm_accept) begin
      stm_wr_valid = ($urandom_range(3) != 0);
      stm_wr_drive = 16'($urandom);
      if (stm_fill_cnt < FILL_WRITES) begin
        stm_wr_pattern = PAT_W'(stm_fill_cnt / NUM_TRANS);
        stm_wr_addr    = ADDR_W'(stm_fill_cnt % NUM_TRANS);
      end else begin
        stm_wr_pattern = PAT_W'($urandom_range(NUM_PATTERNS - 1));
        stm_wr_addr    = ADDR_W'($urandom_range(NUM_TRANS - 1));
      end
    end
    stm_accept = stm_wr_valid && stm_wr_ready;
    if (stm_accept) begin
      model_stm[stm_wr_pattern][stm_wr_addr] = stm_wr_drive;
      stm_fill_cnt++;
    end
  endtask

  // mode changes happen mid-period, well away from the burst window.
  // with a cycle of five, the burst of period p carries index p mod 5.
  task automatic change_mode(input int period);
    case (period)
      3: begin
        ctrl.op_mode = 1'b1;
      end
      8: begin
        ctrl.op_mode        = 1'b0;
        ctrl.use_finish_idx = 1'b1;
        ctrl.finish_idx     = 16'd2;
      end
      // still waiting for index 2 here.
      9: begin
        ctrl.op_mode = 1'b1;
      end
      10: begin
        ctrl.op_mode = 1'b0;
      end
      14: begin
        ctrl.op_mode        = 1'b1;
        ctrl.use_start_idx  = 1'b1;
        ctrl.start_idx      = 16'd3;
        ctrl.use_finish_idx = 1'b0;
      end
      20: begin
        ctrl.op_mode = 1'b0;
      end
      default: ;
    endcase
    settle_mode(ctrl);
  endtask

  task automatic run_cycle(input int period, input sys_time_t t);
    check_time("sys_time", sys_time, t);
    if (t == 0) begin
      start_period(ctrl);
    end
    check_pwm("pwm", pwm, predict_pwm(t));
    check_ready("normal_wr_ready", normal_wr_ready, int'(t) >= NUM_TRANS);
    check_ready("stm_wr_ready", stm_wr_ready, int'(t) >= NUM_TRANS);
    if (int'(t) == MODE_TIME) begin
      change_mode(period);
    end
    drive_normal_write();
    drive_stm_write();
  endtask

  // **********************************************************************
  // main sequence and watchdog
  // **********************************************************************

  initial begin
    void'($urandom(SEED));
    arst_n          = 1'b0;
    ctrl            = '0;
    ctrl.stm_cycle  = STM_CYCLE;
    normal_wr_valid = 1'b0;
    normal_wr_addr  = '0;
    normal_wr_drive = '0;
    stm_wr_valid    = 1'b0;
    stm_wr_pattern  = '0;
    stm_wr_addr     = '0;
    stm_wr_drive    = '0;
    normal_accept   = 1'b0;
    stm_accept      = 1'b0;
    stm_fill_cnt    = 0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    arst_n = 1'b1;
    reset_model();
    for (int p = 0; p < NUM_PERIODS; p++) begin
      for (int t = 0; t < PERIOD_CYCLES; t++) begin
        run_cycle(p, sys_time_t'(t));
        @(posedge CLK);
        #1;
      end
    end
    $display("Test completed successfully");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("the run did not finish before the watchdog expired");
    $display("Test failed");
    $fatal(1);
  end

endmodule

// File: transducer_array.f
+incdir+verification
common/drive_pkg.sv
normal_source/normal_source.sv
stm_source/stm_source.sv
verilog/drive_mux.sv
verilog/drive_distributor.sv
verilog/pwm_channel.sv
verilog/transducer_array.sv
verification/transducer_array_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module transducer_array_tb \
		-f transducer_array.f -o transducer_array_sim
	./obj_dir/transducer_array_sim | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
